/* files.f */
+incdir+.
rv_isa_pkg.sv
rv_ctrl_pkg.sv
rv_decoder.sv
rv_regfile.sv
rv_execute.sv
rv_pc_unit.sv
rv_core.sv
tb_rv_core.sv

/* Makefile */
VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
TOP       := tb_rv_core
FILELIST  := files.f
OBJ_DIR   := obj_dir
SIM       := $(OBJ_DIR)/V$(TOP)
SOURCES   := $(shell grep -v '^+' $(FILELIST)) tb_rv_iss.svh

.PHONY: all run clean

all: run

# rebuilt only when a source or the file list changes
$(SIM): $(SOURCES) $(FILELIST)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: $(SIM)
	@out="$$(./$(SIM))"; \
	echo "$$out"; \
	echo "$$out" | grep -q "^Result: PASSED$$"

clean:
	rm -rf $(OBJ_DIR)

/* tb_rv_iss.svh */
`ifndef TB_RV_ISS_SVH
`define TB_RV_ISS_SVH

  localparam int          ProgWords = 48;
  localparam int          ImemWords = 256;
  localparam int          DmemWords = 64;
  localparam logic [31:0] BasePc    = 32'h0000_0100;
  localparam int          BaseIdx   = 64;
  localparam logic [31:0] Ecall     = 32'h0000_0073;
  localparam logic [31:0] Nop       = 32'h0000_0013;

  logic [31:0] rng;
  logic [31:0] imem [ImemWords];
  // architectural state of the reference model
  logic [31:0] m_regs [32];
  logic [31:0] m_dmem [DmemWords];
  logic [31:0] m_pc;

  function automatic logic [31:0] xorshift32(input logic [31:0] x);
    x = x ^ (x << 13);
    x = x ^ (x >> 17);
    x = x ^ (x << 5);
    return x;
  endfunction

  function automatic logic [31:0] next_rand();
    rng = xorshift32(rng);
    return rng;
  endfunction

  // x0..x7 only, so results get reused often
  function automatic logic [4:0] pick_reg();
    return 5'(next_rand() % 8);
  endfunction

  function automatic logic [31:0] dmem_fill(input int idx, input int prog);
    return (32'(idx) * 32'h9e37_79b1) ^ {8'(prog), 24'h5a_5a5a};
  endfunction

  function automatic logic [31:0] alu_model(input logic [2:0] f3, input logic alt,
                                            input logic [31:0] x, input logic [31:0] y);
    case (f3)
      3'b000:  return alt ? x - y : x + y;
      3'b001:  return x << y[4:0];
      3'b010:  return {31'b0, $signed(x) < $signed(y)};
      3'b011:  return {31'b0, x < y};
      3'b100:  return x ^ y;
      3'b101:  return alt ? 32'($signed(x) >>> y[4:0]) : x >> y[4:0];
      3'b110:  return x | y;
      default: return x & y;
    endcase
  endfunction

  task automatic reset_model(input int prog);
    for (int k = 0; k < 32; k++) begin
      m_regs[k] = '0;
    end
    for (int k = 0; k < DmemWords; k++) begin
      m_dmem[k] = dmem_fill(k, prog);
    end
    m_pc = BasePc;
  endtask

  // forward-only control flow, so every program reaches the final ecall
  task automatic gen_program();
    logic [31:0] r;
    logic [2:0]  f3;
    logic [6:0]  f7;
    logic [11:0] imm;
    logic [12:0] boff;
    logic [20:0] joff;
    int          span;
    int          tgt;
    int          sel;
    for (int k = 0; k < ImemWords; k++) begin
      imem[k] = {16'hbad0, 16'(k)};
    end
    for (int i = 0; i < ProgWords - 1; i++) begin
      r    = next_rand();
      span = (ProgWords - 1 - i > 4) ? 4 : ProgWords - 1 - i;
      tgt  = i + 1 + int'(next_rand() % 32'(span));
      f3   = r[14:12];
      f7   = (r[30] && (f3 == 3'b000 || f3 == 3'b101)) ? 7'b0100000 : 7'b0000000;
      boff = 13'((tgt - i) * 4);
      joff = 21'((tgt - i) * 4);
      sel  = int'(next_rand() % 12);
      case (sel)
        0: imem[BaseIdx + i] = {r[31:12], pick_reg(), 7'b0110111};
        1: imem[BaseIdx + i] = {r[31:12], pick_reg(), 7'b0010111};
        2, 3: begin
          if (f3 == 3'b001) begin
            imm = {7'b0, r[24:20]};
          end else if (f3 == 3'b101) begin
            imm = {f7, r[24:20]};
          end else begin
            imm = r[31:20];
          end
          imem[BaseIdx + i] = {imm, pick_reg(), f3, pick_reg(), 7'b0010011};
        end
        4, 5: imem[BaseIdx + i] = {f7, pick_reg(), pick_reg(), f3, pick_reg(), 7'b0110011};
        6: begin
          // 010 and 011 are not branches
          if (f3[2:1] == 2'b01) begin
            f3[2] = 1'b1;
          end
          imem[BaseIdx + i] = {boff[12], boff[10:5], pick_reg(), pick_reg(), f3,
                               boff[4:1], boff[11], 7'b1100011};
        end
        7: imem[BaseIdx + i] = {joff[20], joff[10:1], joff[11], joff[19:12], pick_reg(),
                                7'b1101111};
        8: begin
          // absolute target from x0, bit 0 sometimes set
          imm = 12'(BasePc + 32'(tgt) * 4) | {11'b0, r[0]};
          imem[BaseIdx + i] = {imm, 5'd0, 3'b000, pick_reg(), 7'b1100111};
        end
        9: imem[BaseIdx + i] = {4'b0, r[7:2], 2'b00, 5'd0, 3'b010, pick_reg(), 7'b0000011};
        default: begin
          imm = {4'b0, r[7:2], 2'b00};
          imem[BaseIdx + i] = {imm[11:5], pick_reg(), 5'd0, 3'b010, imm[4:0], 7'b0100011};
        end
      endcase
    end
    imem[BaseIdx + ProgWords - 1] = Ecall;
  endtask

  task automatic execute_insn(input logic [31:0] insn, output logic st_we, output logic is_mem,
                              output logic is_halt, output logic [31:0] addr,
                              output logic [31:0] wdata);
    logic [31:0] a;
    logic [31:0] b;
    logic [31:0] res;
    logic [31:0] nxt;
    logic [31:0] imm_i;
    logic [31:0] imm_s;
    logic [31:0] imm_b;
    logic [31:0] imm_j;
    logic [2:0]  f3;
    logic        wr;
    logic        take;
    a       = m_regs[insn[19:15]];
    b       = m_regs[insn[24:20]];
    f3      = insn[14:12];
    imm_i   = {{20{insn[31]}}, insn[31:20]};
    imm_s   = {{20{insn[31]}}, insn[31:25], insn[11:7]};
    imm_b   = {{19{insn[31]}}, insn[31], insn[7], insn[30:25], insn[11:8], 1'b0};
    imm_j   = {{11{insn[31]}}, insn[31], insn[19:12], insn[20], insn[30:21], 1'b0};
    nxt     = m_pc + 32'd4;
    res     = '0;
    wr      = 1'b0;
    take    = 1'b0;
    st_we   = 1'b0;
    is_mem  = 1'b0;
    is_halt = (insn == Ecall);
    addr    = '0;
    wdata   = '0;
    case (insn[6:0])
      7'b0110111: begin
        res = {insn[31:12], 12'b0};
        wr  = 1'b1;
      end
      7'b0010111: begin
        res = m_pc + {insn[31:12], 12'b0};
        wr  = 1'b1;
      end
      7'b0010011: begin
        res = alu_model(f3, insn[30] && f3 == 3'b101, a, imm_i);
        wr  = 1'b1;
      end
      7'b0110011: begin
        res = alu_model(f3, insn[30], a, b);
        wr  = 1'b1;
      end
      7'b1101111: begin
        res = nxt;
        nxt = m_pc + imm_j;
        wr  = 1'b1;
      end
      7'b1100111: begin
        res = nxt;
        nxt = (a + imm_i) & ~32'd1;
        wr  = 1'b1;
      end
      7'b1100011: begin
        case (f3)
          3'b000:  take = (a == b);
          3'b001:  take = (a != b);
          3'b100:  take = ($signed(a) < $signed(b));
          3'b101:  take = ($signed(a) >= $signed(b));
          3'b110:  take = (a < b);
          default: take = (a >= b);
        endcase
        if (take) begin
          nxt = m_pc + imm_b;
        end
      end
      7'b0000011: begin
        is_mem = 1'b1;
        addr   = a + imm_i;
        res    = m_dmem[addr[7:2]];
        wr     = 1'b1;
      end
      7'b0100011: begin
        is_mem = 1'b1;
        st_we  = 1'b1;
        addr   = a + imm_s;
        wdata  = b;
        m_dmem[addr[7:2]] = b;
      end
      default: wr = 1'b0;
    endcase
    if (wr && insn[11:7] != 5'd0) begin
      m_regs[insn[11:7]] = res;
    end
    m_pc = nxt;
  endtask

`endif

/* tb_rv_core.sv */
`timescale 1ns/1ps

module tb_rv_core;

  `include "tb_rv_iss.svh"

  localparam int NumPrograms = 6;
  localparam int MaxCycles   = 200;
  // sw x0, 0(x0)
  localparam logic [31:0] StoreInsn = 32'h0000_2023;

  logic        clk;
  logic        rst;
  logic [31:0] imem_addr;
  logic [31:0] imem_data;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_wdata;
  logic        dmem_we;
  logic [31:0] dmem_rdata;
  logic        halt;
  // data memory seen by the DUT, separate from the model copy
  logic [31:0] dmem [DmemWords];

  rv_core #(
    .RESET_PC (BasePc)
  ) i_dut (
    .clk          (clk),
    .rst          (rst),
    .o_imem_addr  (imem_addr),
    .i_imem_data  (imem_data),
    .o_dmem_addr  (dmem_addr),
    .o_dmem_wdata (dmem_wdata),
    .o_dmem_we    (dmem_we),
    .i_dmem_rdata (dmem_rdata),
    .o_halt       (halt)
  );

  initial begin
    clk = 1'b0;
    forever begin
      #50 clk = ~clk;
    end
  end

  task automatic stop_with_failure();
    $display("Result: FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_mismatch(input string what, input logic [31:0] exp,
                                 input logic [31:0] got);
    $display("** Error at %0t: %s expected %h, got %h", $time, what, exp, got);
    stop_with_failure();
  endtask

  task automatic apply_reset();
    rst = 1'b1;
    // a store is presented so the write enable has to be held low by reset
    imem_data  = StoreInsn;
    dmem_rdata = '0;
    repeat (8) begin
      @(posedge clk);
      assert (dmem_we === 1'b0)
        else report_mismatch("dmem write enable in reset", 32'd0, {31'b0, dmem_we});
    end
    @(negedge clk);
    rst = 1'b0;
  endtask

  task automatic run_program(input int prog);
    logic [31:0] insn;
    logic [31:0] exp_pc;
    logic [31:0] exp_addr;
    logic [31:0] exp_wdata;
    logic        exp_we;
    logic        exp_mem;
    logic        exp_halt;
    bit          halted;
    int          cycles;
    halted = 1'b0;
    cycles = 0;
    gen_program();
    reset_model(prog);
    for (int k = 0; k < DmemWords; k++) begin
      dmem[k] = dmem_fill(k, prog);
    end
    apply_reset();
    while (!halted) begin
      if (cycles == MaxCycles) begin
        $display("timeout: program %0d did not raise halt within %0d cycles", prog, MaxCycles);
        stop_with_failure();
      end
      // fetch on the falling edge, load data once the address has settled
      imem_data = imem[imem_addr[9:2]];
      #1;
      dmem_rdata = dmem[dmem_addr[7:2]];
      @(posedge clk);
      insn   = imem_data;
      exp_pc = m_pc;
      execute_insn(insn, exp_we, exp_mem, exp_halt, exp_addr, exp_wdata);
      assert (imem_addr === exp_pc) else report_mismatch("pc", exp_pc, imem_addr);
      assert (dmem_we === exp_we)
        else report_mismatch("dmem write enable", {31'b0, exp_we}, {31'b0, dmem_we});
      if (exp_mem) begin
        assert (dmem_addr === exp_addr) else report_mismatch("dmem address", exp_addr, dmem_addr);
      end
      if (exp_we) begin
        assert (dmem_wdata === exp_wdata)
          else report_mismatch("dmem write data", exp_wdata, dmem_wdata);
        dmem[dmem_addr[7:2]] = dmem_wdata;
      end
      assert (halt === exp_halt) else report_mismatch("halt", {31'b0, exp_halt}, {31'b0, halt});
      halted = halt;
      cycles++;
      @(negedge clk);
    end
  endtask

  initial begin
    rst        = 1'b1;
    imem_data  = Nop;
    dmem_rdata = '0;
    rng        = 32'd49372;
    for (int p = 0; p < NumPrograms; p++) begin
      run_program(p);
    end
    $display("Result: PASSED");
    $finish;
  end

endmodule

/* rv_core.sv */
`timescale 1ns/1ps

module rv_core #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic              clk,
  input  logic              rst,
  output rv_isa_pkg::word_t o_imem_addr,
  input  rv_isa_pkg::word_t i_imem_data,
  output rv_isa_pkg::word_t o_dmem_addr,
  output rv_isa_pkg::word_t o_dmem_wdata,
  output logic              o_dmem_we,
  input  rv_isa_pkg::word_t i_dmem_rdata,
  output logic              o_halt
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  reg_idx_t rs1;
  reg_idx_t rs2;
  reg_idx_t rd;
  word_t    imm;
  alu_op_t  alu_op;
  opa_sel_t opa_sel;
  opb_sel_t opb_sel;
  wb_sel_t  wb_sel;
  pc_sel_t  pc_sel;
  br_cond_t br_cond;
  logic     reg_we;
  word_t    rs1_data;
  word_t    rs2_data;
  word_t    wb_data;
  word_t    alu_result;
  logic     br_taken;
  word_t    pc;
  word_t    link;

  rv_decoder i_decoder (
    .rst       (rst),
    .i_insn    (i_imem_data),
    .o_rs1     (rs1),
    .o_rs2     (rs2),
    .o_rd      (rd),
    .o_imm     (imm),
    .o_alu_op  (alu_op),
    .o_opa_sel (opa_sel),
    .o_opb_sel (opb_sel),
    .o_wb_sel  (wb_sel),
    .o_pc_sel  (pc_sel),
    .o_br_cond (br_cond),
    .o_reg_we  (reg_we),
    .o_mem_we  (o_dmem_we),
    .o_halt    (o_halt)
  );

  rv_regfile i_regfile (
    .clk        (clk),
    .rst        (rst),
    .i_we       (reg_we),
    .i_rd       (rd),
    .i_rd_data  (wb_data),
    .i_rs1      (rs1),
    .i_rs2      (rs2),
    .o_rs1_data (rs1_data),
    .o_rs2_data (rs2_data)
  );

  rv_execute i_execute (
    .i_rs1_data   (rs1_data),
    .i_rs2_data   (rs2_data),
    .i_pc         (pc),
    .i_imm        (imm),
    .i_link       (link),
    .i_dmem_rdata (i_dmem_rdata),
    .i_alu_op     (alu_op),
    .i_opa_sel    (opa_sel),
    .i_opb_sel    (opb_sel),
    .i_wb_sel     (wb_sel),
    .i_br_cond    (br_cond),
    .o_alu_result (alu_result),
    .o_wb_data    (wb_data),
    .o_br_taken   (br_taken)
  );

  rv_pc_unit #(
    .RESET_PC (RESET_PC)
  ) i_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .i_pc_sel     (pc_sel),
    .i_br_taken   (br_taken),
    .i_imm        (imm),
    .i_alu_result (alu_result),
    .o_pc         (pc),
    .o_link       (link)
  );

  assign o_imem_addr  = pc;
  // rs1 + imm, for loads and stores
  assign o_dmem_addr  = alu_result;
  assign o_dmem_wdata = rs2_data;

endmodule

/* rv_pc_unit.sv */
`timescale 1ns/1ps

module rv_pc_unit #(
  parameter rv_isa_pkg::word_t RESET_PC = '0
) (
  input  logic                 clk,
  input  logic                 rst,
  input  rv_ctrl_pkg::pc_sel_t i_pc_sel,
  input  logic                 i_br_taken,
  input  rv_isa_pkg::word_t    i_imm,
  input  rv_isa_pkg::word_t    i_alu_result,
  output rv_isa_pkg::word_t    o_pc,
  output rv_isa_pkg::word_t    o_link
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t pc_q;
  word_t pc_next;
  word_t pc_plus4;
  word_t pc_target;

  assign pc_plus4  = pc_q + 32'd4;
  // shared by branches and jal
  assign pc_target = pc_q + i_imm;

  always_comb begin
    case (i_pc_sel)
      PcBranch: pc_next = i_br_taken ? pc_target : pc_plus4;
      PcJal:    pc_next = pc_target;
      // jalr target has bit 0 cleared
      PcJalr:   pc_next = {i_alu_result[31:1], 1'b0};
      default:  pc_next = pc_plus4;
    endcase
  end

  // advances every cycle, halt or not
  always_ff @(posedge clk) begin
    if (rst) begin
      pc_q <= RESET_PC;
    end else begin
      pc_q <= pc_next;
    end
  end

  assign o_pc   = pc_q;
  assign o_link = pc_plus4;

endmodule

/* rv_execute.sv */
`timescale 1ns/1ps

module rv_execute (
  input  rv_isa_pkg::word_t     i_rs1_data,
  input  rv_isa_pkg::word_t     i_rs2_data,
  input  rv_isa_pkg::word_t     i_pc,
  input  rv_isa_pkg::word_t     i_imm,
  input  rv_isa_pkg::word_t     i_link,
  input  rv_isa_pkg::word_t     i_dmem_rdata,
  input  rv_ctrl_pkg::alu_op_t  i_alu_op,
  input  rv_ctrl_pkg::opa_sel_t i_opa_sel,
  input  rv_ctrl_pkg::opb_sel_t i_opb_sel,
  input  rv_ctrl_pkg::wb_sel_t  i_wb_sel,
  input  rv_ctrl_pkg::br_cond_t i_br_cond,
  output rv_isa_pkg::word_t     o_alu_result,
  output rv_isa_pkg::word_t     o_wb_data,
  output logic                  o_br_taken
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  word_t      opa;
  word_t      opb;
  logic [4:0] shamt;
  logic       rs_eq;
  logic       rs_lt;
  logic       rs_ltu;

  assign opa   = (i_opa_sel == OpaPc) ? i_pc : i_rs1_data;
  assign opb   = (i_opb_sel == OpbImm) ? i_imm : i_rs2_data;
  assign shamt = opb[4:0];

  always_comb begin
    case (i_alu_op)
      AluAdd:  o_alu_result = opa + opb;
      AluSub:  o_alu_result = opa - opb;
      AluSll:  o_alu_result = opa << shamt;
      AluSlt:  o_alu_result = {31'b0, $signed(opa) < $signed(opb)};
      AluSltu: o_alu_result = {31'b0, opa < opb};
      AluXor:  o_alu_result = opa ^ opb;
      AluSrl:  o_alu_result = opa >> shamt;
      AluSra:  o_alu_result = word_t'($signed(opa) >>> shamt);
      AluOr:   o_alu_result = opa | opb;
      AluAnd:  o_alu_result = opa & opb;
      default: o_alu_result = '0;
    endcase
  end

  // branch compare always on rs1 and rs2
  assign rs_eq  = (i_rs1_data == i_rs2_data);
  assign rs_lt  = ($signed(i_rs1_data) < $signed(i_rs2_data));
  assign rs_ltu = (i_rs1_data < i_rs2_data);

  always_comb begin
    case (i_br_cond)
      BrEq:    o_br_taken = rs_eq;
      BrNe:    o_br_taken = !rs_eq;
      BrLt:    o_br_taken = rs_lt;
      BrGe:    o_br_taken = !rs_lt;
      BrLtu:   o_br_taken = rs_ltu;
      BrGeu:   o_br_taken = !rs_ltu;
      default: o_br_taken = 1'b0;
    endcase
  end

  // write-back source
  always_comb begin
    case (i_wb_sel)
      WbLoad:  o_wb_data = i_dmem_rdata;
      WbLink:  o_wb_data = i_link;
      WbUpper: o_wb_data = i_imm;
      default: o_wb_data = o_alu_result;
    endcase
  end

endmodule

/* rv_regfile.sv */
`timescale 1ns/1ps

module rv_regfile (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 i_we,
  input  rv_isa_pkg::reg_idx_t i_rd,
  input  rv_isa_pkg::word_t    i_rd_data,
  input  rv_isa_pkg::reg_idx_t i_rs1,
  input  rv_isa_pkg::reg_idx_t i_rs2,
  output rv_isa_pkg::word_t    o_rs1_data,
  output rv_isa_pkg::word_t    o_rs2_data
);
  import rv_isa_pkg::*;

  word_t regs [NumRegs];

  // asynchronous reads
  assign o_rs1_data = regs[i_rs1];
  assign o_rs2_data = regs[i_rs2];

  // x0 is cleared by reset and never written
  always_ff @(posedge clk) begin
    if (rst) begin
      for (int i = 0; i < NumRegs; i++) begin
        regs[i] <= '0;
      end
    end else if (i_we && i_rd != '0) begin
      regs[i_rd] <= i_rd_data;
    end
  end

endmodule

/* rv_decoder.sv */
`timescale 1ns/1ps

module rv_decoder (
  input  logic                  rst,
  input  rv_isa_pkg::word_t     i_insn,
  output rv_isa_pkg::reg_idx_t  o_rs1,
  output rv_isa_pkg::reg_idx_t  o_rs2,
  output rv_isa_pkg::reg_idx_t  o_rd,
  output rv_isa_pkg::word_t     o_imm,
  output rv_ctrl_pkg::alu_op_t  o_alu_op,
  output rv_ctrl_pkg::opa_sel_t o_opa_sel,
  output rv_ctrl_pkg::opb_sel_t o_opb_sel,
  output rv_ctrl_pkg::wb_sel_t  o_wb_sel,
  output rv_ctrl_pkg::pc_sel_t  o_pc_sel,
  output rv_ctrl_pkg::br_cond_t o_br_cond,
  output logic                  o_reg_we,
  output logic                  o_mem_we,
  output logic                  o_halt
);
  import rv_isa_pkg::*;
  import rv_ctrl_pkg::*;

  opcode_t    opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  word_t      imm_i;
  word_t      imm_s;
  word_t      imm_b;
  word_t      imm_j;
  word_t      imm_u;
  alu_op_t    arith_op;
  logic       arith_ok;
  logic       is_reg_reg;
  logic       reg_we;
  logic       mem_we;

  assign opcode = i_insn[6:0];
  assign funct3 = i_insn[14:12];
  assign funct7 = i_insn[31:25];
  assign o_rd   = i_insn[11:7];
  assign o_rs1  = i_insn[19:15];
  assign o_rs2  = i_insn[24:20];

  // sign-extended immediates
  assign imm_i = {{20{i_insn[31]}}, i_insn[31:20]};
  assign imm_s = {{20{i_insn[31]}}, i_insn[31:25], i_insn[11:7]};
  assign imm_b = {{19{i_insn[31]}}, i_insn[31], i_insn[7], i_insn[30:25], i_insn[11:8], 1'b0};
  assign imm_j = {{11{i_insn[31]}}, i_insn[31], i_insn[19:12], i_insn[20], i_insn[30:21], 1'b0};
  assign imm_u = {i_insn[31:12], 12'b0};

  assign is_reg_reg = (opcode == OpRegReg);

  // alu op from funct3/funct7, shared by reg-imm and reg-reg
  always_comb begin
    arith_op = AluAdd;
    arith_ok = 1'b0;
    case (funct3)
      F3AddSub: begin
        arith_op = (is_reg_reg && funct7 == Funct7Alt) ? AluSub : AluAdd;
        arith_ok = !is_reg_reg || funct7 == Funct7Base || funct7 == Funct7Alt;
      end
      F3Sll: begin
        arith_op = AluSll;
        arith_ok = (funct7 == Funct7Base);
      end
      F3SrlSra: begin
        arith_op = (funct7 == Funct7Alt) ? AluSra : AluSrl;
        arith_ok = (funct7 == Funct7Base) || (funct7 == Funct7Alt);
      end
      F3Slt: begin
        arith_op = AluSlt;
        arith_ok = !is_reg_reg || funct7 == Funct7Base;
      end
      F3Sltu: begin
        arith_op = AluSltu;
        arith_ok = !is_reg_reg || funct7 == Funct7Base;
      end
      F3Xor: begin
        arith_op = AluXor;
        arith_ok = !is_reg_reg || funct7 == Funct7Base;
      end
      F3Or: begin
        arith_op = AluOr;
        arith_ok = !is_reg_reg || funct7 == Funct7Base;
      end
      default: begin
        arith_op = AluAnd;
        arith_ok = !is_reg_reg || funct7 == Funct7Base;
      end
    endcase
  end

  // per-opcode control, unknown encodings fall through as no-ops
  always_comb begin
    o_imm     = imm_i;
    o_alu_op  = AluAdd;
    o_opa_sel = OpaRs1;
    o_opb_sel = OpbImm;
    o_wb_sel  = WbAlu;
    o_pc_sel  = PcSeq;
    o_br_cond = br_cond_t'(funct3);
    reg_we    = 1'b0;
    mem_we    = 1'b0;
    o_halt    = 1'b0;
    case (opcode)
      OpLui: begin
        o_imm    = imm_u;
        o_wb_sel = WbUpper;
        reg_we   = 1'b1;
      end
      OpAuipc: begin
        o_imm     = imm_u;
        o_opa_sel = OpaPc;
        reg_we    = 1'b1;
      end
      OpJal: begin
        o_imm    = imm_j;
        o_wb_sel = WbLink;
        o_pc_sel = PcJal;
        reg_we   = 1'b1;
      end
      OpJalr: begin
        o_wb_sel = WbLink;
        o_pc_sel = PcJalr;
        reg_we   = 1'b1;
      end
      OpBranch: begin
        o_imm = imm_b;
        case (funct3)
          F3Beq, F3Bne, F3Blt, F3Bge, F3Bltu, F3Bgeu: o_pc_sel = PcBranch;
          default: o_pc_sel = PcSeq;
        endcase
      end
      OpLoad: begin
        o_wb_sel = WbLoad;
        reg_we   = (funct3 == F3Word);
      end
      OpStore: begin
        o_imm  = imm_s;
        mem_we = (funct3 == F3Word);
      end
      OpRegImm, OpRegReg: begin
        o_alu_op  = arith_op;
        o_opb_sel = is_reg_reg ? OpbRs2 : OpbImm;
        reg_we    = arith_ok;
      end
      // only ecall, all other system encodings ignored
      OpEnviron: o_halt = (i_insn[31:7] == '0);
      default: reg_we = 1'b0;
    endcase
  end

  // no side effects while in reset
  assign o_reg_we = reg_we & ~rst;
  assign o_mem_we = mem_we & ~rst;

endmodule

/* rv_ctrl_pkg.sv */
package rv_ctrl_pkg;

  typedef enum logic [3:0] {
    AluAdd,
    AluSub,
    AluSll,
    AluSlt,
    AluSltu,
    AluXor,
    AluSrl,
    AluSra,
    AluOr,
    AluAnd
  } alu_op_t;

  typedef enum logic {OpbRs2, OpbImm} opb_sel_t;

  // pc as operand a only for auipc
  typedef enum logic {OpaRs1, OpaPc} opa_sel_t;

  typedef enum logic [1:0] {WbAlu, WbLoad, WbLink, WbUpper} wb_sel_t;

  typedef enum logic [1:0] {PcSeq, PcBranch, PcJal, PcJalr} pc_sel_t;

  // same coding as the branch funct3
  typedef enum logic [2:0] {
    BrEq  = rv_isa_pkg::F3Beq,
    BrNe  = rv_isa_pkg::F3Bne,
    BrLt  = rv_isa_pkg::F3Blt,
    BrGe  = rv_isa_pkg::F3Bge,
    BrLtu = rv_isa_pkg::F3Bltu,
    BrGeu = rv_isa_pkg::F3Bgeu
  } br_cond_t;

endpackage

/* rv_isa_pkg.sv */
package rv_isa_pkg;

  // architectural word and register index
  typedef logic [31:0] word_t;
  typedef logic [4:0]  reg_idx_t;
  typedef logic [6:0]  opcode_t;

  localparam int NumRegs = 32;

  // major opcodes
  localparam opcode_t OpLui     = 7'b0110111;
  localparam opcode_t OpAuipc   = 7'b0010111;
  localparam opcode_t OpJal     = 7'b1101111;
  localparam opcode_t OpJalr    = 7'b1100111;
  localparam opcode_t OpBranch  = 7'b1100011;
  localparam opcode_t OpLoad    = 7'b0000011;
  localparam opcode_t OpStore   = 7'b0100011;
  localparam opcode_t OpRegImm  = 7'b0010011;
  localparam opcode_t OpRegReg  = 7'b0110011;
  localparam opcode_t OpEnviron = 7'b1110011;

  // funct7, alt selects sub and sra
  localparam logic [6:0] Funct7Base = 7'b0000000;
  localparam logic [6:0] Funct7Alt  = 7'b0100000;

  // branch funct3
  localparam logic [2:0] F3Beq  = 3'b000;
  localparam logic [2:0] F3Bne  = 3'b001;
  localparam logic [2:0] F3Blt  = 3'b100;
  localparam logic [2:0] F3Bge  = 3'b101;
  localparam logic [2:0] F3Bltu = 3'b110;
  localparam logic [2:0] F3Bgeu = 3'b111;

  // lw and sw
  localparam logic [2:0] F3Word = 3'b010;

  // alu funct3, shared by reg-imm and reg-reg
  localparam logic [2:0] F3AddSub = 3'b000;
  localparam logic [2:0] F3Sll    = 3'b001;
  localparam logic [2:0] F3Slt    = 3'b010;
  localparam logic [2:0] F3Sltu   = 3'b011;
  localparam logic [2:0] F3Xor    = 3'b100;
  localparam logic [2:0] F3SrlSra = 3'b101;
  localparam logic [2:0] F3Or     = 3'b110;
  localparam logic [2:0] F3And    = 3'b111;

endpackage
